// ==== bp_config.svh ====
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// ------------------------------
// table and stack geometry
// ------------------------------
`define BP_INDEX_BITS 6
`define BP_RAS_DEPTH 8

// ------------------------------
// fetch addresses
// ------------------------------
`define BP_RESET_PC 32'hbfc00000
`define BP_EXC_VECTOR_RESET 32'hbfc00380

// wishbone word addresses of the configuration registers.
`define BP_ADR_CTRL 2'd0
`define BP_ADR_EXC 2'd1
`define BP_ADR_PRED 2'd2
`define BP_ADR_MISS 2'd3

`endif

// ==== bp_pkg.sv ====
`default_nettype none

`include "bp_config.svh"

package bp_pkg;

    // instruction address.
    typedef logic [31:0] addr_t;

    // table index, taken from the pc bits above the 8-byte block offset.
    typedef logic [`BP_INDEX_BITS-1:0] idx_t;

    // 2-bit direction counter, values 2 and 3 predict taken.
    typedef logic [1:0] sat2_t;

    // repeat counter of one stack entry.
    typedef logic [7:0] ras_cnt_t;

    // stack top pointer.
    typedef logic [$clog2(`BP_RAS_DEPTH)-1:0] ras_ptr_t;

    // register select of the wishbone slave.
    typedef enum logic [1:0] {
        CTRL       = `BP_ADR_CTRL,
        EXC_VECTOR = `BP_ADR_EXC,
        PRED_COUNT = `BP_ADR_PRED,
        MISS_COUNT = `BP_ADR_MISS
    } csr_sel_t;

endpackage

`default_nettype wire

// ==== bp_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_predictor (
    input  logic          clk,
    input  logic          resetn,
    input  bp_pkg::addr_t pc,
    input  logic          pred_en,
    input  logic          tbl_clear,
    input  logic          dec_valid,
    input  bp_pkg::addr_t dec_pc,
    input  logic          dec_is_ret,
    input  logic          ex_valid,
    input  bp_pkg::addr_t ex_pc,
    input  logic          ex_taken,
    input  bp_pkg::addr_t ex_target,
    input  logic          ras_valid,
    input  bp_pkg::addr_t ras_top_pc,
    output logic          pred_taken,
    output bp_pkg::addr_t pred_pc
);
    import bp_pkg::*;

    localparam int tbl_size = 1 << `BP_INDEX_BITS;

    sat2_t pht [tbl_size];
    addr_t btb [tbl_size];
    logic  ret_flag [tbl_size];

    idx_t  rd_idx;
    idx_t  ex_idx;
    idx_t  dec_idx;
    sat2_t ex_cnt;

    logic  hit_taken;
    addr_t hit_target;
    logic  is_ret;

    assign rd_idx  = pc[3 +: `BP_INDEX_BITS];
    assign ex_idx  = ex_pc[3 +: `BP_INDEX_BITS];
    assign dec_idx = dec_pc[3 +: `BP_INDEX_BITS];

    // ------------------------------
    // lookup
    // ------------------------------
    assign hit_taken  = pht[rd_idx][1];   // upper bit set means 2 or 3.
    assign hit_target = btb[rd_idx];
    assign is_ret     = ret_flag[rd_idx];

    always_comb begin
        pred_taken = 1'b0;
        pred_pc    = hit_target;
        if (is_ret && ras_valid) begin
            pred_taken = 1'b1;
            pred_pc    = ras_top_pc;
        end else if (hit_taken && hit_target != '0) begin
            // an empty target entry is treated as not taken.
            pred_taken = 1'b1;
        end
        if (!pred_en) begin
            pred_taken = 1'b0;
        end
    end

    // ------------------------------
    // training
    // ------------------------------
    assign ex_cnt = pht[ex_idx];

    always_ff @(posedge clk) begin
        if (!resetn || tbl_clear) begin
            for (int i = 0; i < tbl_size; i++) begin
                pht[i] <= 2'd1;                // weakly not taken.
            end
        end else if (ex_valid) begin
            if (ex_taken) begin
                if (ex_cnt != 2'd3) begin
                    pht[ex_idx] <= ex_cnt + 2'd1;
                end
            end else if (ex_cnt != 2'd0) begin
                pht[ex_idx] <= ex_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || tbl_clear) begin
            for (int i = 0; i < tbl_size; i++) begin
                btb[i] <= '0;
            end
        end else if (ex_valid && ex_taken) begin
            btb[ex_idx] <= ex_target;
        end
    end

    // decode marks whether the block ends in a return.
    always_ff @(posedge clk) begin
        if (!resetn || tbl_clear) begin
            for (int i = 0; i < tbl_size; i++) begin
                ret_flag[i] <= 1'b0;
            end
        end else if (dec_valid) begin
            ret_flag[dec_idx] <= dec_is_ret;
        end
    end

endmodule

`default_nettype wire

// ==== bp_ras.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_ras (
    input  logic          clk,
    input  logic          resetn,
    input  logic          ras_en,
    input  logic          tbl_clear,
    input  logic          ex_valid,
    input  logic          ex_is_call,
    input  logic          ex_is_ret,
    input  bp_pkg::addr_t ex_pc,
    output logic          ras_valid,
    output bp_pkg::addr_t ras_top_pc
);
    import bp_pkg::*;

    addr_t    ras_pc [`BP_RAS_DEPTH];
    ras_cnt_t ras_cnt [`BP_RAS_DEPTH];
    ras_ptr_t top;
    ras_ptr_t top_up;
    addr_t    push_pc;

    assign push_pc = ex_pc + 32'd8;      // return address of the call.
    assign top_up  = top + 1'b1;         // wraps from the last entry to 0.

    assign ras_top_pc = ras_pc[top];
    assign ras_valid  = ras_en && (ras_pc[top] != '0);

    always_ff @(posedge clk) begin
        if (!resetn || tbl_clear) begin
            top <= '0;
            for (int i = 0; i < `BP_RAS_DEPTH; i++) begin
                ras_pc[i]  <= '0;
                ras_cnt[i] <= '0;
            end
        end else if (ex_valid && ex_is_ret) begin
            if (ras_cnt[top] == '0) begin
                ras_pc[top] <= '0;
                top         <= top - 1'b1;
            end else begin
                ras_cnt[top] <= ras_cnt[top] - 8'd1;
            end
        end else if (ex_valid && ex_is_call) begin
            // a repeated call to the same site only bumps the counter.
            if (ras_pc[top] == push_pc && ras_cnt[top] != 8'hff) begin
                ras_cnt[top] <= ras_cnt[top] + 8'd1;
            end else begin
                top             <= top_up;
                ras_pc[top_up]  <= push_pc;
                ras_cnt[top_up] <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bp_fetch_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_fetch_pc (
    input  logic          clk,
    input  logic          resetn,
    input  logic          fetch_ready,
    input  logic          exc_flush,
    input  logic          eret,
    input  bp_pkg::addr_t epc,
    input  logic          mispredict,
    input  bp_pkg::addr_t recover_pc,
    input  bp_pkg::addr_t exc_vector,
    input  logic          pred_taken,
    input  bp_pkg::addr_t pred_pc,
    output bp_pkg::addr_t pc
);
    import bp_pkg::*;

    addr_t seq_pc;
    addr_t next_pc;
    logic  redirect;

    assign seq_pc   = {pc[31:3], 3'b000} + 32'd8;
    assign redirect = exc_flush || eret || mispredict;

    // fixed priority, redirects first.
    always_comb begin
        if (exc_flush) begin
            next_pc = exc_vector;
        end else if (eret) begin
            next_pc = epc;
        end else if (mispredict) begin
            next_pc = recover_pc;
        end else if (pred_taken) begin
            next_pc = pred_pc;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= `BP_RESET_PC;
        end else if (fetch_ready || redirect) begin   // redirects ignore a stall.
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== bp_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_csr (
    input  logic          clk,
    input  logic          resetn,
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  logic [1:0]    wb_adr,
    input  logic [31:0]   wb_dat_w,
    output logic [31:0]   wb_dat_r,
    output logic          wb_ack,
    input  logic          pred_taken,
    input  logic          fetch_ready,
    input  logic          mispredict,
    output logic          pred_en,
    output logic          ras_en,
    output logic          tbl_clear,
    output bp_pkg::addr_t exc_vector
);
    import bp_pkg::*;

    csr_sel_t    sel;
    logic        req;
    logic        wr;
    logic [31:0] pred_count;
    logic [31:0] miss_count;

    assign sel = csr_sel_t'(wb_adr);
    assign req = wb_cyc && wb_stb && !wb_ack;   // idle one cycle after each ack.
    assign wr  = req && wb_we;

    // ------------------------------
    // bus handshake and read data
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            case (sel)
                CTRL:       wb_dat_r <= {30'b0, ras_en, pred_en};   // clear bit reads 0.
                EXC_VECTOR: wb_dat_r <= exc_vector;
                PRED_COUNT: wb_dat_r <= pred_count;
                MISS_COUNT: wb_dat_r <= miss_count;
                default:    wb_dat_r <= '0;
            endcase
        end
    end

    // ------------------------------
    // control and vector
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pred_en    <= 1'b1;
            ras_en     <= 1'b1;
            tbl_clear  <= 1'b0;
            exc_vector <= `BP_EXC_VECTOR_RESET;
        end else begin
            tbl_clear <= wr && sel == CTRL && wb_dat_w[2];
            if (wr && sel == CTRL) begin
                pred_en <= wb_dat_w[0];
                ras_en  <= wb_dat_w[1];
            end
            if (wr && sel == EXC_VECTOR) begin
                exc_vector <= wb_dat_w;
            end
        end
    end

    // event counters, a write of any value clears them.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pred_count <= '0;
            miss_count <= '0;
        end else begin
            if (wr && sel == PRED_COUNT) begin
                pred_count <= '0;
            end else if (fetch_ready && pred_taken) begin
                pred_count <= pred_count + 32'd1;
            end
            if (wr && sel == MISS_COUNT) begin
                miss_count <= '0;
            end else if (mispredict) begin
                miss_count <= miss_count + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bp_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module bp_frontend (
    input  logic          clk,
    input  logic          resetn,
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  logic [1:0]    wb_adr,
    input  logic [31:0]   wb_dat_w,
    output logic [31:0]   wb_dat_r,
    output logic          wb_ack,
    input  logic          ex_valid,
    input  bp_pkg::addr_t ex_pc,
    input  logic          ex_taken,
    input  bp_pkg::addr_t ex_target,
    input  logic          ex_is_call,
    input  logic          ex_is_ret,
    input  logic          dec_valid,
    input  bp_pkg::addr_t dec_pc,
    input  logic          dec_is_ret,
    input  logic          exc_flush,
    input  logic          eret,
    input  bp_pkg::addr_t epc,
    input  logic          mispredict,
    input  bp_pkg::addr_t recover_pc,
    input  logic          fetch_ready,
    output bp_pkg::addr_t pc,
    output logic          pred_taken
);
    import bp_pkg::*;

    logic  pred_en;
    logic  ras_en;
    logic  tbl_clear;
    addr_t exc_vector;
    logic  ras_valid;
    addr_t ras_top_pc;
    addr_t pred_pc;

    bp_csr u_csr (
        .clk(clk), .resetn(resetn),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .pred_taken(pred_taken), .fetch_ready(fetch_ready), .mispredict(mispredict),
        .pred_en(pred_en), .ras_en(ras_en), .tbl_clear(tbl_clear),
        .exc_vector(exc_vector)
    );

    bp_predictor u_predictor (
        .clk(clk), .resetn(resetn), .pc(pc),
        .pred_en(pred_en), .tbl_clear(tbl_clear),
        .dec_valid(dec_valid), .dec_pc(dec_pc), .dec_is_ret(dec_is_ret),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_taken(ex_taken), .ex_target(ex_target),
        .ras_valid(ras_valid), .ras_top_pc(ras_top_pc),
        .pred_taken(pred_taken), .pred_pc(pred_pc)
    );

    bp_ras u_ras (
        .clk(clk), .resetn(resetn), .ras_en(ras_en), .tbl_clear(tbl_clear),
        .ex_valid(ex_valid), .ex_is_call(ex_is_call), .ex_is_ret(ex_is_ret),
        .ex_pc(ex_pc), .ras_valid(ras_valid), .ras_top_pc(ras_top_pc)
    );

    bp_fetch_pc u_fetch_pc (
        .clk(clk), .resetn(resetn), .fetch_ready(fetch_ready),
        .exc_flush(exc_flush), .eret(eret), .epc(epc),
        .mispredict(mispredict), .recover_pc(recover_pc), .exc_vector(exc_vector),
        .pred_taken(pred_taken), .pred_pc(pred_pc), .pc(pc)
    );

endmodule

`default_nettype wire

// ==== bp_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_props (
    input logic          clk,
    input logic          resetn,
    input logic          wb_cyc,
    input logic          wb_stb,
    input logic          wb_ack,
    input logic          pred_en,
    input logic          pred_taken,
    input bp_pkg::addr_t pc
);

    // ack is a single-cycle pulse.
    ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        wb_ack |=> !wb_ack) else $error("wb_ack held longer than one cycle.");

    ack_after_req: assert property (@(posedge clk) disable iff (!resetn)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb)) else $error("wb_ack without request.");

    reset_pc: assert property (@(posedge clk)
        (resetn && !$past(resetn)) |-> pc == `BP_RESET_PC) else $error("pc not reset.");

    // prediction is off while CTRL bit 0 is clear.
    pred_off: assert property (@(posedge clk) disable iff (!resetn)
        !pred_en |-> !pred_taken) else $error("pred_taken while disabled.");

endmodule

bind bp_frontend bp_props u_props (
    .clk(clk), .resetn(resetn), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .pred_en(pred_en), .pred_taken(pred_taken), .pc(pc)
);

`default_nettype wire

// ==== bp_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bp_tb;
    import bp_pkg::*;

    localparam int tbl_size = 1 << `BP_INDEX_BITS;
    localparam int ras_depth = `BP_RAS_DEPTH;

    logic        clk;
    logic        resetn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        ex_valid;
    addr_t       ex_pc;
    logic        ex_taken;
    addr_t       ex_target;
    logic        ex_is_call;
    logic        ex_is_ret;
    logic        dec_valid;
    addr_t       dec_pc;
    logic        dec_is_ret;
    logic        exc_flush;
    logic        eret;
    addr_t       epc;
    logic        mispredict;
    addr_t       recover_pc;
    logic        fetch_ready;
    addr_t       pc;
    logic        pred_taken;

    // parsed test lines.
    logic [127:0] cmds [$];
    logic [127:0] names [$];
    logic [31:0]  fa [$];
    logic [31:0]  fb [$];
    logic [31:0]  fc [$];

    // reference model of the predictor state.
    logic [1:0]  m_pht [tbl_size];
    logic [31:0] m_btb [tbl_size];
    logic        m_ret [tbl_size];
    logic [31:0] m_rpc [ras_depth];
    logic [7:0]  m_rcnt [ras_depth];
    int          m_top;
    logic        m_pred_en;
    logic        m_ras_en;
    logic [31:0] m_vec;
    logic [31:0] m_pc;
    logic [31:0] m_pred_count;
    logic [31:0] m_miss_count;
    logic [31:0] rnd;

    int cycles;
    int cycle_limit;

    bp_frontend dut (.*);

    always #2 clk = ~clk;

    // ------------------------------
    // timeout
    // ------------------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input logic [127:0] name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("error: test %0s expected %h actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic model_clear();
        for (int i = 0; i < tbl_size; i++) begin
            m_pht[i] = 2'd1;
            m_btb[i] = '0;
            m_ret[i] = 1'b0;
        end
        for (int i = 0; i < ras_depth; i++) begin
            m_rpc[i]  = '0;
            m_rcnt[i] = '0;
        end
        m_top = 0;
    endtask

    task automatic model_predict(input logic [31:0] p, output logic taken,
                                 output logic [31:0] tgt);
        int idx;
        idx   = p[3 +: `BP_INDEX_BITS];
        taken = 1'b0;
        tgt   = m_btb[idx];
        if (m_ret[idx] && m_ras_en && m_rpc[m_top] != 0) begin
            taken = 1'b1;
            tgt   = m_rpc[m_top];
        end else if (m_pht[idx] >= 2 && m_btb[idx] != 0) begin
            taken = 1'b1;
        end
        if (!m_pred_en) taken = 1'b0;
    endtask

    task automatic model_train(input logic [31:0] p, input logic [31:0] tgt,
                               input logic [2:0] flags);
        int idx;
        logic [31:0] ra;
        idx = p[3 +: `BP_INDEX_BITS];
        ra  = p + 32'd8;
        if (flags[0]) begin
            if (m_pht[idx] != 3) m_pht[idx] = m_pht[idx] + 1;
            m_btb[idx] = tgt;
        end else if (m_pht[idx] != 0) begin
            m_pht[idx] = m_pht[idx] - 1;
        end
        if (flags[2]) begin
            if (m_rcnt[m_top] == 0) begin
                m_rpc[m_top] = '0;
                m_top = (m_top + ras_depth - 1) % ras_depth;
            end else begin
                m_rcnt[m_top] = m_rcnt[m_top] - 1;
            end
        end else if (flags[1]) begin
            if (m_rpc[m_top] == ra && m_rcnt[m_top] != 8'hff) begin
                m_rcnt[m_top] = m_rcnt[m_top] + 1;
            end else begin
                m_top = (m_top + 1) % ras_depth;
                m_rpc[m_top]  = ra;
                m_rcnt[m_top] = '0;
            end
        end
    endtask

    // one execute strobe, driven on a falling edge.
    task automatic drive_train(input logic [31:0] p, input logic [31:0] tgt,
                               input logic [2:0] flags);
        ex_valid   = 1'b1;
        ex_pc      = p;
        ex_target  = tgt;
        ex_taken   = flags[0];
        ex_is_call = flags[1];
        ex_is_ret  = flags[2];
        @(negedge clk);
        ex_valid   = 1'b0;
        ex_is_call = 1'b0;
        ex_is_ret  = 1'b0;
        model_train(p, tgt, flags);
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr,
                             input logic [31:0] data, output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);                   // lets a table clear take effect.
    endtask

    task automatic load_tests();
        int fd;
        int n;
        logic [8*128-1:0] line;
        logic [127:0] cmd;
        logic [127:0] name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("bp_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file bp_tests.txt");
            $display("CHECKS FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            cmd = '0;
            n = $sscanf(line, "%s %s %h %h %h", cmd, name, a, b, c);
            if (n == 5 && cmd != "#") begin
                cmds.push_back(cmd);
                names.push_back(name);
                fa.push_back(a);
                fb.push_back(b);
                fc.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        logic [31:0] rdata;
        logic [31:0] tgt;
        logic [31:0] exp_pc;
        logic taken;

        clk = 1'b0;
        resetn = 1'b0;
        cycles = 0;
        cycle_limit = 0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        ex_valid = 1'b0;
        ex_pc = '0;
        ex_taken = 1'b0;
        ex_target = '0;
        ex_is_call = 1'b0;
        ex_is_ret = 1'b0;
        dec_valid = 1'b0;
        dec_pc = '0;
        dec_is_ret = 1'b0;
        exc_flush = 1'b0;
        eret = 1'b0;
        epc = '0;
        mispredict = 1'b0;
        recover_pc = '0;
        fetch_ready = 1'b0;
        rnd = 32'hf8d0;

        model_clear();
        m_pred_en = 1'b1;
        m_ras_en = 1'b1;
        m_vec = `BP_EXC_VECTOR_RESET;
        m_pc = `BP_RESET_PC;
        m_pred_count = '0;
        m_miss_count = '0;

        load_tests();
        cycle_limit = 20 * cmds.size() + 16;

        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        foreach (cmds[i]) begin
            case (cmds[i])
                "wbw": begin
                    wb_access(1'b1, fa[i][1:0], fb[i], rdata);
                    case (fa[i][1:0])
                        2'd0: begin
                            m_pred_en = fb[i][0];
                            m_ras_en  = fb[i][1];
                            if (fb[i][2]) model_clear();
                        end
                        2'd1: m_vec = fb[i];
                        2'd2: m_pred_count = '0;
                        default: m_miss_count = '0;
                    endcase
                end
                "wbr": begin
                    wb_access(1'b0, fa[i][1:0], '0, rdata);
                    case (fa[i][1:0])
                        2'd0: check_value(names[i], fb[i], {30'b0, m_ras_en, m_pred_en});
                        2'd1: check_value(names[i], fb[i], m_vec);
                        2'd2: check_value(names[i], fb[i], m_pred_count);
                        default: check_value(names[i], fb[i], m_miss_count);
                    endcase
                    check_value(names[i], fb[i], rdata);
                end
                "redir": begin
                    exc_flush  = fa[i][0];
                    eret       = fa[i][1];
                    mispredict = fa[i][2];
                    epc        = fb[i];
                    recover_pc = fa[i][1] ? ~fb[i] : fb[i];   // apart from epc when both fire.
                    @(negedge clk);
                    exc_flush = 1'b0;
                    eret = 1'b0;
                    mispredict = 1'b0;
                    if (fa[i][2]) m_miss_count = m_miss_count + 1;
                    m_pc = fa[i][0] ? m_vec : fb[i];
                    check_value(names[i], m_pc, pc);
                end
                "train": drive_train(fa[i], fb[i], fc[i][2:0]);
                "decret": begin
                    dec_valid  = 1'b1;
                    dec_pc     = fa[i];
                    dec_is_ret = fb[i][0];
                    @(negedge clk);
                    dec_valid = 1'b0;
                    m_ret[fa[i][3 +: `BP_INDEX_BITS]] = fb[i][0];
                end
                "stall": begin
                    repeat (fa[i]) @(negedge clk);
                    check_value(names[i], m_pc, pc);
                end
                "fill": begin
                    repeat (fa[i]) begin
                        rnd = xorshift(rnd);
                        drive_train({rnd[31:3], 3'b000}, '0, 3'b000);
                    end
                end
                "expect": begin
                    model_predict(m_pc, taken, tgt);
                    check_value(names[i], fa[i], m_pc);
                    check_value(names[i], fa[i], pc);
                    check_value(names[i], fb[i], {31'b0, taken});
                    check_value(names[i], fb[i], {31'b0, pred_taken});
                end
                "fetch": begin
                    model_predict(m_pc, taken, tgt);
                    exp_pc = taken ? tgt : ({m_pc[31:3], 3'b000} + 32'd8);
                    check_value(names[i], fa[i], exp_pc);
                    fetch_ready = 1'b1;
                    @(negedge clk);
                    fetch_ready = 1'b0;
                    if (taken) m_pred_count = m_pred_count + 1;
                    m_pc = exp_pc;
                    check_value(names[i], exp_pc, pc);
                end
                default: begin
                    $display("unknown command in test %0s", names[i]);
                    $display("CHECKS FAILED");
                    $fatal(1);
                end
            endcase
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bp_tests.txt ====
# columns: command, test name, then three hex fields a b c
# wbw/wbr adr data, redir mask(1 exc 2 eret 4 mispredict) addr, train pc target flags
wbr rst_exc 1 bfc00380 0
wbr rst_pred 2 0 0
wbr rst_miss 3 0 0
wbr rst_ctrl 0 3 0
expect rst_pc bfc00000 0 0
fill fill_nt a 0 0
wbw clr_fill 0 7 0
train tk1 80000040 80002000 1
train tk2 80000040 80002000 1
redir go_blk 4 80000040 0
expect blk_taken 80000040 1 0
fetch blk_next 80002000 0 0
train nt1 80000040 0 0
train nt2 80000040 0 0
redir back 4 80000040 0
expect blk_seq 80000040 0 0
fetch seq_next 80000048 0 0
train call1 80000100 0 2
decret ret_mark 80000210 1 0
redir to_ret 2 80000210 0
expect ret_pred 80000210 1 0
fetch ret_next 80000108 0 0
train call2 80000100 0 2
train ret1 80000300 0 4
redir to_ret2 2 80000210 0
expect ret_still 80000210 1 0
train ret2 80000300 0 4
expect ret_empty 80000210 0 0
wbw vec 1 80000180 0
wbr vec_rd 1 80000180 0
redir all3 7 80000500 0
redir eret_mis 6 80000600 0
redir mis_only 4 80000700 0
redir stl_go 4 80000040 0
train stl_t1 80000040 80003000 1
train stl_t2 80000040 80003000 1
stall stl_hold 3 0 0
fetch stl_next 80003000 0 0
redir dis_go 4 80000040 0
wbw ctrl_off 0 2 0
expect dis_seq 80000040 0 0
fetch dis_next 80000048 0 0
wbw ctrl_on 0 3 0
redir re_go 4 80000040 0
expect re_taken 80000040 1 0
wbw ctrl_clr 0 7 0
expect clr_seq 80000040 0 0
wbr miss_cnt 3 8 0
wbr pred_cnt 2 3 0

// ==== verilog.f ====
+incdir+.
bp_pkg.sv
bp_predictor.sv
bp_ras.sv
bp_fetch_pc.sv
bp_csr.sv
bp_frontend.sv
bp_props.sv
bp_tb.sv
